// File: design/nes_pad_pkg.sv
`default_nettype none

package nes_pad_pkg;

  // button levels, one bit each, as the console reads them:
  // bit 0 A, 1 B, 2 select, 3 start, 4 up, 5 down, 6 left, 7 right
  typedef logic [7:0] pad_bits_t;

  // full serial report of one port, bit 0 goes out first
  // byte 0 primary pad, byte 1 second pad, byte 2 signature
  typedef logic [23:0] report_t;

  // multitap signature bytes, third byte of each report
  localparam logic [7:0] MULTITAP_SIG_PORT1 = 8'h08;
  localparam logic [7:0] MULTITAP_SIG_PORT2 = 8'h04;

  // upper two bytes without multitap
  // a plain pad reads as all ones after its eighth bit
  localparam logic [15:0] NO_TAP_FILL = 16'hFFFF;

endpackage

`default_nettype wire

// File: design/nes_system_pkg.sv
`default_nettype none

package nes_system_pkg;

  // cartridge description from the game loader
  // mapper number in the low byte, board options above it
  typedef logic [63:0] mapper_flags_t;

  // battery backed save present on the board
  localparam int HAS_SAVE_BIT = 25;

  // idle loader cycles still to wait after a download
  typedef logic [7:0] hold_count_t;

endpackage

`default_nettype wire

// File: design/controller_config.sv
`default_nettype none

module controller_config (
  input  wire logic                   clk_ppu_21_47,
  input  wire logic                   reset_nes,
  input  wire logic                   cfg_write,
  input  wire logic                   cfg_multitap,
  input  wire logic                   cfg_swap,
  input  wire nes_pad_pkg::pad_bits_t pad_p1,
  input  wire nes_pad_pkg::pad_bits_t pad_p2,
  input  wire nes_pad_pkg::pad_bits_t pad_p3,
  input  wire nes_pad_pkg::pad_bits_t pad_p4,
  output nes_pad_pkg::pad_bits_t      port1_primary,
  output nes_pad_pkg::pad_bits_t      port1_second,
  output nes_pad_pkg::pad_bits_t      port2_primary,
  output nes_pad_pkg::pad_bits_t      port2_second,
  output logic                        multitap_on
);

  logic multitap_q;
  logic swap_q;

  // both bits written together
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      multitap_q <= 1'b0;
      swap_q     <= 1'b0;
    end else if (cfg_write) begin
      multitap_q <= cfg_multitap;
      swap_q     <= cfg_swap;
    end
  end

  // swap trades the two primary pads only
  assign port1_primary = swap_q ? pad_p2 : pad_p1;
  assign port2_primary = swap_q ? pad_p1 : pad_p2;

  // multitap pads stay on their own port
  assign port1_second = pad_p3;
  assign port2_second = pad_p4;

  assign multitap_on = multitap_q;

endmodule

`default_nettype wire

// File: design/joypad_port.sv
`default_nettype none

module joypad_port #(
  parameter logic [7:0] PORT_SIGNATURE = nes_pad_pkg::MULTITAP_SIG_PORT1
) (
  input  wire logic                   clk_ppu_21_47,
  input  wire logic                   reset_nes,
  input  wire nes_pad_pkg::pad_bits_t primary_pad,
  input  wire nes_pad_pkg::pad_bits_t second_pad,
  input  wire logic                   multitap_on,
  input  wire logic                   latch,
  input  wire logic                   port_clock,
  output logic                        serial_data
);

  import nes_pad_pkg::*;

  report_t report;
  report_t load_value;
  logic    last_clock;
  logic    clock_fall;

  // report as the console will see it, low byte first
  always_comb begin
    if (multitap_on) begin
      load_value = {PORT_SIGNATURE, second_pad, primary_pad};
    end else begin
      load_value = {NO_TAP_FILL, primary_pad};
    end
  end

  // the core drops the clock line to advance to the next bit
  assign clock_fall = !port_clock && last_clock;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      report     <= '0;
      last_clock <= 1'b0;
    end else begin
      last_clock <= port_clock;
      // a falling edge takes priority over a held latch
      if (clock_fall) begin
        report <= {1'b0, report[$bits(report_t)-1:1]};
      end else if (latch) begin
        report <= load_value;
      end
    end
  end

  assign serial_data = report[0];

endmodule

`default_nettype wire

// File: design/load_reset_sequencer.sv
`default_nettype none

module load_reset_sequencer #(
  parameter int DOWNLOAD_HOLD_CYCLES = 255
) (
  input  wire logic                          clk_ppu_21_47,
  input  wire logic                          reset_nes,
  input  wire logic                          downloading,
  input  wire logic                          loader_busy,
  input  wire logic                          loader_done,
  input  wire logic                          loader_fail,
  input  wire logic                          hold_reset,
  input  wire nes_system_pkg::mapper_flags_t loader_flags,
  output logic                               core_reset,
  output logic                               loader_reset,
  output nes_system_pkg::mapper_flags_t      mapper_flags,
  output logic                               has_save
);

  import nes_system_pkg::*;

  logic        init_done;
  hold_count_t hold_cnt;
  logic        hold_active;
  logic        last_downloading;
  logic        download_rise;

  // core stays in reset until the first download is seen
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      init_done <= 1'b0;
    end else if (downloading) begin
      init_done <= 1'b1;
    end
  end

  // restart the wait for the whole download,
  // count only while the loader sits idle
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      hold_cnt <= '0;
    end else if (downloading) begin
      hold_cnt <= hold_count_t'(DOWNLOAD_HOLD_CYCLES);
    end else if (!loader_busy && hold_active) begin
      hold_cnt <= hold_cnt - hold_count_t'(1);
    end
  end

  assign hold_active   = (hold_cnt != '0);
  assign download_rise = downloading && !last_downloading;

  // loader kept in reset once the hold has run out,
  // pulsed again at the start of every download
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      last_downloading <= 1'b0;
      loader_reset     <= 1'b1;
    end else begin
      last_downloading <= downloading;
      loader_reset     <= !hold_active || download_rise;
    end
  end

  assign core_reset = !init_done || hold_active || loader_fail || hold_reset;

  // cartridge description for the rest of the system
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      mapper_flags <= '0;
    end else if (loader_done) begin
      mapper_flags <= loader_flags;
    end
  end

  assign has_save = mapper_flags[HAS_SAVE_BIT];

endmodule

`default_nettype wire

// File: design/nes_io_top.sv
`default_nettype none

module nes_io_top #(
  parameter int DOWNLOAD_HOLD_CYCLES = 255
) (
  input  wire logic                          clk_ppu_21_47,
  input  wire logic                          reset_nes,
  input  wire nes_pad_pkg::pad_bits_t        pad_p1,
  input  wire nes_pad_pkg::pad_bits_t        pad_p2,
  input  wire nes_pad_pkg::pad_bits_t        pad_p3,
  input  wire nes_pad_pkg::pad_bits_t        pad_p4,
  input  wire logic                          cfg_write,
  input  wire logic                          cfg_multitap,
  input  wire logic                          cfg_swap,
  input  wire logic                          joypad_latch,
  input  wire logic [1:0]                    joypad_clock,
  input  wire logic                          downloading,
  input  wire logic                          loader_busy,
  input  wire logic                          loader_done,
  input  wire logic                          loader_fail,
  input  wire logic                          hold_reset,
  input  wire nes_system_pkg::mapper_flags_t loader_flags,
  output wire logic                          joypad1_data,
  output wire logic                          joypad2_data,
  output wire logic                          core_reset,
  output wire logic                          loader_reset,
  output wire nes_system_pkg::mapper_flags_t mapper_flags,
  output wire logic                          has_save
);

  import nes_pad_pkg::*;

  pad_bits_t port1_primary;
  pad_bits_t port1_second;
  pad_bits_t port2_primary;
  pad_bits_t port2_second;
  logic      multitap_on;

  controller_config config_regs (
    .clk_ppu_21_47(clk_ppu_21_47),
    .reset_nes    (reset_nes),
    .cfg_write    (cfg_write),
    .cfg_multitap (cfg_multitap),
    .cfg_swap     (cfg_swap),
    .pad_p1       (pad_p1),
    .pad_p2       (pad_p2),
    .pad_p3       (pad_p3),
    .pad_p4       (pad_p4),
    .port1_primary(port1_primary),
    .port1_second (port1_second),
    .port2_primary(port2_primary),
    .port2_second (port2_second),
    .multitap_on  (multitap_on)
  );

  // both ports share the latch line, each has its own clock
  joypad_port #(
    .PORT_SIGNATURE(MULTITAP_SIG_PORT1)
  ) port1 (
    .clk_ppu_21_47(clk_ppu_21_47),
    .reset_nes    (reset_nes),
    .primary_pad  (port1_primary),
    .second_pad   (port1_second),
    .multitap_on  (multitap_on),
    .latch        (joypad_latch),
    .port_clock   (joypad_clock[0]),
    .serial_data  (joypad1_data)
  );

  joypad_port #(
    .PORT_SIGNATURE(MULTITAP_SIG_PORT2)
  ) port2 (
    .clk_ppu_21_47(clk_ppu_21_47),
    .reset_nes    (reset_nes),
    .primary_pad  (port2_primary),
    .second_pad   (port2_second),
    .multitap_on  (multitap_on),
    .latch        (joypad_latch),
    .port_clock   (joypad_clock[1]),
    .serial_data  (joypad2_data)
  );

  load_reset_sequencer #(
    .DOWNLOAD_HOLD_CYCLES(DOWNLOAD_HOLD_CYCLES)
  ) sequencer (
    .clk_ppu_21_47(clk_ppu_21_47),
    .reset_nes    (reset_nes),
    .downloading  (downloading),
    .loader_busy  (loader_busy),
    .loader_done  (loader_done),
    .loader_fail  (loader_fail),
    .hold_reset   (hold_reset),
    .loader_flags (loader_flags),
    .core_reset   (core_reset),
    .loader_reset (loader_reset),
    .mapper_flags (mapper_flags),
    .has_save     (has_save)
  );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 20
) (
  output logic clk
);

  // free running, first rising edge at half a period
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = !clk;
  end

endmodule

`default_nettype wire

// File: testbench/nes_io_chk.sv
`default_nettype none

module nes_io_chk (
  input wire logic                          clk_ppu_21_47,
  input wire logic                          reset_nes,
  input wire logic                          downloading,
  input wire logic                          core_reset,
  input wire logic                          loader_reset,
  input wire logic                          loader_fail,
  input wire logic                          loader_done,
  input wire nes_system_pkg::mapper_flags_t loader_flags,
  input wire logic                          has_save,
  input wire logic                          joypad_latch,
  input wire logic [1:0]                    joypad_clock,
  input wire logic                          joypad1_data,
  input wire logic                          joypad2_data
);

  import nes_system_pkg::*;

  // a download loads the hold counter, so the core sits in reset after it
  hold_keeps_reset: assert property (@(posedge clk_ppu_21_47) disable iff (reset_nes)
    downloading |=> core_reset)
    else $error("core_reset low after a download started the hold");

  fail_forces_reset: assert property (@(posedge clk_ppu_21_47) disable iff (reset_nes)
    loader_fail |-> core_reset)
    else $error("core_reset low during a loader failure");

  save_flag_follows: assert property (@(posedge clk_ppu_21_47) disable iff (reset_nes)
    (!$past(reset_nes) && $past(loader_done)) |->
      has_save == $past(loader_flags[HAS_SAVE_BIT]))
    else $error("has_save differs from the loaded save bit");

  reset_holds_loader: assert property (@(posedge clk_ppu_21_47)
    reset_nes |=> loader_reset)
    else $error("loader_reset low right after a system reset");

  // data may only move one edge after a latch or a port clock fall
  port1_data_stable: assert property (@(posedge clk_ppu_21_47) disable iff (reset_nes)
    (!$past(reset_nes) && !$past(joypad_latch) &&
     !($past(joypad_clock[0], 2) && !$past(joypad_clock[0]))) |-> $stable(joypad1_data))
    else $error("port 1 data moved without a latch or clock fall");

  port2_data_stable: assert property (@(posedge clk_ppu_21_47) disable iff (reset_nes)
    (!$past(reset_nes) && !$past(joypad_latch) &&
     !($past(joypad_clock[1], 2) && !$past(joypad_clock[1]))) |-> $stable(joypad2_data))
    else $error("port 2 data moved without a latch or clock fall");

endmodule

bind nes_io_top nes_io_chk checks (
  .clk_ppu_21_47(clk_ppu_21_47),
  .reset_nes    (reset_nes),
  .downloading  (downloading),
  .core_reset   (core_reset),
  .loader_reset (loader_reset),
  .loader_fail  (loader_fail),
  .loader_done  (loader_done),
  .loader_flags (loader_flags),
  .has_save     (has_save),
  .joypad_latch (joypad_latch),
  .joypad_clock (joypad_clock),
  .joypad1_data (joypad1_data),
  .joypad2_data (joypad2_data)
);

`default_nettype wire

// File: testbench/tb_nes_io.sv
`default_nettype none

module tb_nes_io;

  import nes_pad_pkg::*;
  import nes_system_pkg::*;

  // limit sits far above the few hundred cycles the sequence needs
  localparam int MAX_CYCLES  = 4000;
  localparam int HOLD_CYCLES = 12;

  logic          clk_ppu_21_47;
  logic          reset_nes;
  pad_bits_t     pad_p1;
  pad_bits_t     pad_p2;
  pad_bits_t     pad_p3;
  pad_bits_t     pad_p4;
  logic          cfg_write;
  logic          cfg_multitap;
  logic          cfg_swap;
  logic          joypad_latch;
  logic [1:0]    joypad_clock;
  logic          downloading;
  logic          loader_busy;
  logic          loader_done;
  logic          loader_fail;
  logic          hold_reset;
  mapper_flags_t loader_flags;
  logic          joypad1_data;
  logic          joypad2_data;
  logic          core_reset;
  logic          loader_reset;
  mapper_flags_t mapper_flags;
  logic          has_save;
  int            seed;
  int            cycle_count = 0;
  int            idle_seen;
  int            step;

  tb_clock_gen #(.PERIOD(20)) clock_source (.clk(clk_ppu_21_47));

  nes_io_top #(
    .DOWNLOAD_HOLD_CYCLES(HOLD_CYCLES)
  ) uut (
    .clk_ppu_21_47(clk_ppu_21_47),
    .reset_nes    (reset_nes),
    .pad_p1       (pad_p1),
    .pad_p2       (pad_p2),
    .pad_p3       (pad_p3),
    .pad_p4       (pad_p4),
    .cfg_write    (cfg_write),
    .cfg_multitap (cfg_multitap),
    .cfg_swap     (cfg_swap),
    .joypad_latch (joypad_latch),
    .joypad_clock (joypad_clock),
    .downloading  (downloading),
    .loader_busy  (loader_busy),
    .loader_done  (loader_done),
    .loader_fail  (loader_fail),
    .hold_reset   (hold_reset),
    .loader_flags (loader_flags),
    .joypad1_data (joypad1_data),
    .joypad2_data (joypad2_data),
    .core_reset   (core_reset),
    .loader_reset (loader_reset),
    .mapper_flags (mapper_flags),
    .has_save     (has_save)
  );

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    assert (actual === expected) else
      fail_run($sformatf("Error at %0t: %s expected %b, actual %b",
                         $time, name, expected, actual));
  endtask

  task automatic check_flags(input mapper_flags_t expected, input mapper_flags_t actual);
    assert (actual === expected) else
      fail_run($sformatf("Error at %0t: mapper_flags expected %h, actual %h",
                         $time, expected, actual));
  endtask

  // bit n of a port report
  // first pad, then second pad or ones, then signature or ones
  // and zeros once everything has shifted out
  function automatic logic report_bit(input int index, input pad_bits_t first,
                                      input pad_bits_t second, input logic [7:0] sig,
                                      input logic multitap);
    logic [2:0] pos;
    pos = index[2:0];
    if (index < 8) return first[pos];
    if (index < 16) return multitap ? second[pos] : 1'b1;
    if (index < 24) return multitap ? sig[pos] : 1'b1;
    return 1'b0;
  endfunction

  task automatic new_pads();
    pad_p1 = pad_bits_t'($random(seed));
    pad_p2 = pad_bits_t'($random(seed));
    pad_p3 = pad_bits_t'($random(seed));
    pad_p4 = pad_bits_t'($random(seed));
  endtask

  task automatic write_config(input logic multitap, input logic swap);
    cfg_write    = 1'b1;
    cfg_multitap = multitap;
    cfg_swap     = swap;
    @(negedge clk_ppu_21_47);
    cfg_write = 1'b0;
  endtask

  // latch both ports, then clock out 24 bits plus two trailing zeros
  task automatic serial_read(input pad_bits_t p1_first, p1_second, p2_first, p2_second,
                             input logic multitap);
    joypad_latch = 1'b1;
    @(negedge clk_ppu_21_47);
    joypad_latch = 1'b0;
    for (int i = 0; i < 26; i++) begin
      check_bit("joypad1_data",
                report_bit(i, p1_first, p1_second, MULTITAP_SIG_PORT1, multitap),
                joypad1_data);
      check_bit("joypad2_data",
                report_bit(i, p2_first, p2_second, MULTITAP_SIG_PORT2, multitap),
                joypad2_data);
      joypad_clock = 2'b00;
      @(negedge clk_ppu_21_47);
      joypad_clock = 2'b11;
      repeat (2) @(negedge clk_ppu_21_47);
    end
  endtask

  always @(posedge clk_ppu_21_47) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      fail_run("Timeout: the tests did not finish within the cycle limit");
    end
  end

  initial begin
    seed = 75;
    reset_nes = 1'b1;
    pad_p1 = '0;
    pad_p2 = '0;
    pad_p3 = '0;
    pad_p4 = '0;
    cfg_write = 1'b0;
    cfg_multitap = 1'b0;
    cfg_swap = 1'b0;
    joypad_latch = 1'b0;
    joypad_clock = 2'b11;
    downloading = 1'b0;
    loader_busy = 1'b0;
    loader_done = 1'b0;
    loader_fail = 1'b0;
    hold_reset = 1'b0;
    loader_flags = '0;
    repeat (2) @(negedge clk_ppu_21_47);
    reset_nes = 1'b0;

    // nothing downloaded yet after reset
    check_bit("core_reset", 1'b1, core_reset);
    check_bit("loader_reset", 1'b1, loader_reset);
    check_bit("joypad1_data", 1'b0, joypad1_data);
    check_bit("joypad2_data", 1'b0, joypad2_data);
    repeat (4) begin
      @(negedge clk_ppu_21_47);
      check_bit("core_reset", 1'b1, core_reset);
    end

    // plain pads, multitap, then swapped primaries
    new_pads();
    serial_read(pad_p1, pad_p3, pad_p2, pad_p4, 1'b0);
    write_config(1'b1, 1'b0);
    new_pads();
    serial_read(pad_p1, pad_p3, pad_p2, pad_p4, 1'b1);
    write_config(1'b1, 1'b1);
    new_pads();
    serial_read(pad_p2, pad_p3, pad_p1, pad_p4, 1'b1);

    // download, then count idle loader cycles with busy gaps
    downloading = 1'b1;
    loader_busy = 1'b1;
    repeat (3) @(negedge clk_ppu_21_47);
    downloading = 1'b0;
    check_bit("loader_reset", 1'b0, loader_reset);
    idle_seen = 0;
    step = 0;
    while (idle_seen < HOLD_CYCLES) begin
      check_bit("core_reset", 1'b1, core_reset);
      loader_busy = (step % 3 == 1);
      @(negedge clk_ppu_21_47);
      if (!loader_busy) idle_seen++;
      step++;
    end
    loader_busy = 1'b0;
    check_bit("core_reset", 1'b0, core_reset);
    @(negedge clk_ppu_21_47);
    check_bit("loader_reset", 1'b1, loader_reset);

    loader_fail = 1'b1;
    @(negedge clk_ppu_21_47);
    check_bit("core_reset", 1'b1, core_reset);
    loader_fail = 1'b0;
    @(negedge clk_ppu_21_47);
    check_bit("core_reset", 1'b0, core_reset);
    hold_reset = 1'b1;
    @(negedge clk_ppu_21_47);
    check_bit("core_reset", 1'b1, core_reset);
    hold_reset = 1'b0;
    @(negedge clk_ppu_21_47);
    check_bit("core_reset", 1'b0, core_reset);

    // cartridge flags with and without a battery save
    for (int pass = 0; pass < 2; pass++) begin
      loader_flags = {$random(seed), $random(seed)};
      loader_flags[HAS_SAVE_BIT] = (pass == 0);
      loader_done = 1'b1;
      @(negedge clk_ppu_21_47);
      loader_done = 1'b0;
      @(negedge clk_ppu_21_47);
      check_flags(loader_flags, mapper_flags);
      check_bit("has_save", (pass == 0), has_save);
    end
    // flags hold once loader_done is low
    loader_flags = ~loader_flags;
    @(negedge clk_ppu_21_47);
    check_flags(~loader_flags, mapper_flags);

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
design/nes_pad_pkg.sv
design/nes_system_pkg.sv
design/controller_config.sv
design/joypad_port.sv
design/load_reset_sequencer.sv
design/nes_io_top.sv
testbench/tb_clock_gen.sv
testbench/nes_io_chk.sv
testbench/tb_nes_io.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_nes_io -f sim.f -o tb_nes_io \
  && ./obj_dir/tb_nes_io \
  || { echo "simulation did not complete successfully"; exit 1; }
